/* ras_predictor.f */
+incdir+rtl
+incdir+tb
rtl/ras_predictor_pkg.sv
rtl/fetch_branch_decode.sv
rtl/call_target_calc.sv
rtl/ras_stack.sv
rtl/ras_predictor.sv
tb/tb_ras_predictor.sv

/* build.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary -j 0 --top-module tb_ras_predictor -f ras_predictor.f
out=$(./obj_dir/Vtb_ras_predictor)
echo "$out"
if echo "$out" | grep -qx "all tests passed"; then
  exit 0
fi
exit 1

/* tb/tb_ras_model.svh */
  // reference model of fetch decode and return address stack
  // plus the random block generator that feeds it

  localparam int K_NONE  = 0;
  localparam int K_CALL  = 1;
  localparam int K_RET   = 2;
  localparam int K_OTHER = 3;

  logic [31:0] lfsr_state;

  hw_addr_t    m_stack [`RAS_ENTRIES];
  ras_index_t  m_index;
  logic        m_prev_seen;
  hw_addr_t    m_prev_base;
  logic        m_prev_last_32;
  logic [15:0] m_prev_last_hw;

  // model response to the stimulus of this cycle
  logic        cur_call;
  hw_addr_t    cur_call_target;
  logic        cur_ret;
  hw_addr_t    cur_ret_target;
  ras_index_t  cur_index;

  hw_addr_t    gen_last_va;
  logic        pend_valid;
  logic [15:0] pend_hi;

  // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int k = 0; k < n; k++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  task automatic model_reset();
    for (int i = 0; i < `RAS_ENTRIES; i++) begin
      m_stack[i] = '0;
    end
    m_index        = '0;
    m_prev_seen    = 1'b0;
    m_prev_base    = '0;
    m_prev_last_32 = 1'b0;
    m_prev_last_hw = '0;
    gen_last_va    = hw_addr_t'(32'h0000_2000);
    pend_valid     = 1'b0;
    pend_hi        = '0;
  endtask

  // ----------------------------------------
  // instruction classes
  // ----------------------------------------
  function automatic int classify_half(input logic [15:0] h);
    // c.j
    if (h[1:0] == 2'b01 && h[15:13] == 3'b101) begin
      return K_OTHER;
    end
    // c.jr and c.jalr
    if (h[1:0] == 2'b10 && h[15:13] == 3'b100 && h[11:7] != 5'd0 && h[6:2] == 5'd0) begin
      if (h[12] == 1'b0 && h[11:7] == 5'd1) begin
        return K_RET;
      end
      return K_OTHER;
    end
    return K_NONE;
  endfunction

  function automatic int classify_word(input logic [31:0] w);
    if (w[6:0] == 7'h6f) begin
      return (w[11:7] == 5'd1) ? K_CALL : K_OTHER;
    end
    if (w[6:0] == 7'h67 && w[14:12] == 3'b000) begin
      if (w[11:7] == 5'd0 && w[19:15] == 5'd1 && w[31:20] == 12'd0) begin
        return K_RET;
      end
      return K_OTHER;
    end
    return K_NONE;
  endfunction

  // ----------------------------------------
  // one cycle of decode and stack
  // ----------------------------------------
  task automatic model_step(input logic fv, input hw_addr_t va, input block_data_t data,
                            input hw_mask_t en, input logic fl, input ras_index_t fi);
    hw_addr_t                base;
    logic                    upper;
    logic [15:0]             h;
    logic [15:0]             lo;
    int                      kind;
    int                      win_kind;
    int                      win_pos;
    logic [31:0]             win_inst;
    logic [`RAS_VADDR_W-1:0] pc_b;
    logic [`RAS_VADDR_W-1:0] imm_b;
    logic [`RAS_VADDR_W-1:0] nxt_b;
    ras_index_t              sp;
    ras_index_t              below;
    sp       = fl ? fi : m_index;
    cur_call = 1'b0;
    cur_ret  = 1'b0;
    win_kind = K_NONE;
    win_pos  = 0;
    win_inst = '0;
    if (fv) begin
      base  = va & ~hw_addr_t'(`RAS_BLOCK_HW - 1);
      upper = m_prev_seen && m_prev_last_32 &&
              (base == m_prev_base + hw_addr_t'(`RAS_BLOCK_HW));
      lo    = m_prev_last_hw;
      for (int p = 0; p < `RAS_BLOCK_HW; p++) begin
        h = data[p*16 +: 16];
        if (upper) begin
          kind  = classify_word({h, lo});
          upper = 1'b0;
        end else begin
          kind  = classify_half(h);
          upper = (h[1:0] == 2'b11);
        end
        if (en[p] && kind != K_NONE && win_kind == K_NONE) begin
          win_kind = kind;
          win_pos  = p;
          win_inst = {h, lo};
        end
        lo = h;
      end
      m_prev_seen    = 1'b1;
      m_prev_base    = base;
      m_prev_last_32 = upper;
      m_prev_last_hw = lo;

      // byte pc of the call one halfword before its upper half
      pc_b  = {base + hw_addr_t'(win_pos) - hw_addr_t'(1), 1'b0};
      imm_b = {{(`RAS_VADDR_W-21){win_inst[31]}}, win_inst[31], win_inst[19:12],
               win_inst[20], win_inst[30:21], 1'b0};
      below = sp - ras_index_t'(1);
      if (win_kind == K_CALL) begin
        cur_call        = 1'b1;
        nxt_b           = pc_b + imm_b;
        cur_call_target = nxt_b[`RAS_VADDR_W-1:1];
        nxt_b           = pc_b + `RAS_VADDR_W'(4);
        m_stack[sp]     = nxt_b[`RAS_VADDR_W-1:1];
        sp              = sp + ras_index_t'(1);
      end else if (win_kind == K_RET) begin
        cur_ret        = 1'b1;
        cur_ret_target = m_stack[below];
        sp             = below;
      end
    end
    m_index   = sp;
    cur_index = sp;
  endtask

  // ----------------------------------------
  // block generator
  // ----------------------------------------
  task automatic build_block(input logic follow, output block_data_t data);
    logic [31:0] word;
    logic [15:0] half;
    logic        wide;
    logic [4:0]  rs;
    int          p;
    data = '0;
    p    = 0;
    // upper half of the last straddler is now and then kept after a jump too
    if (pend_valid && (follow || lfsr_bits(1) == 1)) begin
      data[15:0] = pend_hi;
      p = 1;
    end
    pend_valid = 1'b0;
    while (p < `RAS_BLOCK_HW) begin
      wide = 1'b0;
      word = '0;
      half = '0;
      rs   = 5'(lfsr_bits(5)) | 5'd2;
      case (3'(lfsr_bits(3)))
        3'd0: half = {3'b000, 11'(lfsr_bits(11)), 2'b01};
        3'd1: half = {3'b101, 11'(lfsr_bits(11)), 2'b01};
        3'd2: begin
          // c.jr ra or jalr x0, 0(ra)
          half = 16'h8082;
          word = 32'h0000_8067;
          wide = (lfsr_bits(1) == 1);
        end
        3'd3: half = {3'b100, 1'(lfsr_bits(1)), rs, 5'd0, 2'b10};
        3'd4, 3'd5: begin
          word = {20'(lfsr_bits(20)), 5'd1, 7'h6f};
          wide = 1'b1;
        end
        3'd6: begin
          if (lfsr_bits(1) == 1) begin
            word = {20'(lfsr_bits(20)), rs, 7'h6f};
          end else begin
            word = {12'(lfsr_bits(12)), rs, 3'b000, 5'(lfsr_bits(5)), 7'h67};
          end
          wide = 1'b1;
        end
        default: begin
          word = {17'(lfsr_bits(17)), 3'b000, rs, 7'h13};
          wide = 1'b1;
        end
      endcase
      if (!wide) begin
        data[p*16 +: 16] = half;
        p++;
      end else if (p == `RAS_BLOCK_HW - 1) begin
        // straddles into the next block
        data[p*16 +: 16] = word[15:0];
        pend_hi    = word[31:16];
        pend_valid = 1'b1;
        p++;
      end else begin
        data[p*16 +: 16]     = word[15:0];
        data[(p+1)*16 +: 16] = word[31:16];
        p += 2;
      end
    end
  endtask

  task automatic pick_stimulus();
    logic [31:0] hi;
    logic [31:0] lo;
    logic        follow;
    st_valid     = (lfsr_bits(3) != 0);
    st_flush     = (lfsr_bits(4) == 0);
    st_flush_idx = ras_index_t'(lfsr_bits(3));
    if (st_valid) begin
      follow = (lfsr_bits(4) < 13);
      if (follow) begin
        st_vaddr = gen_last_va + hw_addr_t'(`RAS_BLOCK_HW);
      end else begin
        hi = lfsr_bits(32);
        lo = lfsr_bits(32);
        st_vaddr = hw_addr_t'({hi, lo}) & ~hw_addr_t'(`RAS_BLOCK_HW - 1);
      end
      build_block(follow, st_data);
      st_en       = (lfsr_bits(2) == 0) ? hw_mask_t'(lfsr_bits(4)) : '1;
      gen_last_va = st_vaddr;
    end
  endtask

/* tb/tb_ras_predictor.sv */
`default_nettype none

`include "ras_predictor_settings.svh"

module tb_ras_predictor
  import ras_predictor_pkg::*;
();

  localparam int RESET_CYCLES   = 3;
  localparam int N_FETCH        = 400;
  // fetch loop plus a quarter for reset and drain
  localparam int TIMEOUT_CYCLES = N_FETCH + N_FETCH / 4;

  logic        i_clk;
  logic        i_reset_n;
  logic        i_fetch_valid;
  hw_addr_t    i_fetch_vaddr;
  block_data_t i_fetch_data;
  hw_mask_t    i_fetch_hw_en;
  logic        i_flush_valid;
  ras_index_t  i_flush_index;
  logic        o_call_valid;
  hw_addr_t    o_call_target;
  logic        o_ret_valid;
  hw_addr_t    o_ret_target;
  ras_index_t  o_ras_index;

  // stimulus of the current cycle
  logic        st_valid;
  hw_addr_t    st_vaddr;
  block_data_t st_data;
  hw_mask_t    st_en;
  logic        st_flush;
  ras_index_t  st_flush_idx;

  // expected outputs one cycle behind the stimulus
  logic        exp_call;
  hw_addr_t    exp_call_target;
  logic        exp_ret;
  hw_addr_t    exp_ret_target;
  ras_index_t  exp_index;

  int          cycle_count;
  int          check_count;
  int          error_count;

  `include "tb_ras_model.svh"

  ras_predictor UUT (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_fetch_valid (i_fetch_valid),
    .i_fetch_vaddr (i_fetch_vaddr),
    .i_fetch_data  (i_fetch_data),
    .i_fetch_hw_en (i_fetch_hw_en),
    .i_flush_valid (i_flush_valid),
    .i_flush_index (i_flush_index),
    .o_call_valid  (o_call_valid),
    .o_call_target (o_call_target),
    .o_ret_valid   (o_ret_valid),
    .o_ret_target  (o_ret_target),
    .o_ras_index   (o_ras_index)
  );

  initial i_clk = 1'b0;
  always #5 i_clk = ~i_clk;

  always @(posedge i_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: stimulus loop still running after %0d cycles", cycle_count);
      $display("tests failed");
      $finish;
    end
  end

  task automatic check_value(input string name, input int cyc,
                             input logic [63:0] expected, input logic [63:0] actual);
    check_count++;
    if (expected !== actual) begin
      error_count++;
      $display("error: %s cycle %0d expected 0x%0h actual 0x%0h",
               name, cyc, expected, actual);
    end
  endtask

  task automatic compare_outputs(input int cyc);
    check_value("call_valid", cyc, 64'(exp_call), 64'(o_call_valid));
    check_value("ret_valid", cyc, 64'(exp_ret), 64'(o_ret_valid));
    check_value("ras_index", cyc, 64'(exp_index), 64'(o_ras_index));
    // targets hold their value without a strobe
    if (exp_call) begin
      check_value("call_target", cyc, 64'(exp_call_target), 64'(o_call_target));
    end
    if (exp_ret) begin
      check_value("ret_target", cyc, 64'(exp_ret_target), 64'(o_ret_target));
    end
  endtask

  // ----------------------------------------
  // stimulus and checking
  // ----------------------------------------
  initial begin
    i_reset_n     = 1'b0;
    i_fetch_valid = 1'b0;
    i_fetch_vaddr = '0;
    i_fetch_data  = '0;
    i_fetch_hw_en = '0;
    i_flush_valid = 1'b0;
    i_flush_index = '0;
    cycle_count   = 0;
    check_count   = 0;
    error_count   = 0;
    lfsr_state    = 32'd79518;
    st_vaddr      = '0;
    st_data       = '0;
    st_en         = '0;
    model_reset();
    // state right after reset
    exp_call        = 1'b0;
    exp_call_target = '0;
    exp_ret         = 1'b0;
    exp_ret_target  = '0;
    exp_index       = '0;

    repeat (RESET_CYCLES) @(posedge i_clk);
    i_reset_n <= 1'b1;

    for (int cyc = 0; cyc <= N_FETCH; cyc++) begin
      @(posedge i_clk);
      if (cyc < N_FETCH) begin
        pick_stimulus();
      end else begin
        st_valid = 1'b0;
        st_flush = 1'b0;
      end
      i_fetch_valid <= st_valid;
      i_fetch_vaddr <= st_vaddr;
      i_fetch_data  <= st_data;
      i_fetch_hw_en <= st_en;
      i_flush_valid <= st_flush;
      i_flush_index <= st_flush_idx;
      model_step(st_valid, st_vaddr, st_data, st_en, st_flush, st_flush_idx);

      // outputs of the previous cycle's stimulus are settled here
      @(negedge i_clk);
      compare_outputs(cyc);
      exp_call        = cur_call;
      exp_call_target = cur_call_target;
      exp_ret         = cur_ret;
      exp_ret_target  = cur_ret_target;
      exp_index       = cur_index;
    end

    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* rtl/ras_predictor.sv */
`default_nettype none

`include "ras_predictor_settings.svh"

module ras_predictor
  import ras_predictor_pkg::*;
(
  input  wire logic        i_clk,
  input  wire logic        i_reset_n,
  input  wire logic        i_fetch_valid,
  input  wire hw_addr_t    i_fetch_vaddr,
  input  wire block_data_t i_fetch_data,
  input  wire hw_mask_t    i_fetch_hw_en,
  input  wire logic        i_flush_valid,
  input  wire ras_index_t  i_flush_index,
  output logic             o_call_valid,
  output hw_addr_t         o_call_target,
  output logic             o_ret_valid,
  output hw_addr_t         o_ret_target,
  output ras_index_t       o_ras_index
);

  localparam int ADDR_W  = $bits(hw_addr_t);
  localparam int BLK_LSB = $clog2(`RAS_BLOCK_HW);

  logic       w_call;
  logic       w_ret;
  hw_pos_t    w_sel_pos;
  inst_word_t w_sel_inst;
  hw_addr_t   w_block_base;
  hw_addr_t   w_call_target;
  hw_addr_t   w_return_addr;
  hw_addr_t   w_pop_addr;

  // halfword address of slot 0
  assign w_block_base = {i_fetch_vaddr[ADDR_W-1:BLK_LSB], {BLK_LSB{1'b0}}};

  fetch_branch_decode u_decode (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_fetch_valid (i_fetch_valid),
    .i_fetch_vaddr (i_fetch_vaddr),
    .i_fetch_data  (i_fetch_data),
    .i_fetch_hw_en (i_fetch_hw_en),
    .o_call        (w_call),
    .o_ret         (w_ret),
    .o_sel_pos     (w_sel_pos),
    .o_sel_inst    (w_sel_inst)
  );

  call_target_calc u_target (
    .i_block_vaddr (w_block_base),
    .i_pos         (w_sel_pos),
    .i_inst        (w_sel_inst),
    .o_call_target (w_call_target),
    .o_return_addr (w_return_addr)
  );

  ras_stack u_stack (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_push        (w_call),
    .i_push_addr   (w_return_addr),
    .i_pop         (w_ret),
    .i_flush_valid (i_flush_valid),
    .i_flush_index (i_flush_index),
    .o_pop_addr    (w_pop_addr),
    .o_index       (o_ras_index)
  );

  // ----------------------------------------
  // prediction outputs one cycle after fetch
  // ----------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_call_valid <= 1'b0;
      o_ret_valid  <= 1'b0;
    end else begin
      o_call_valid <= w_call;
      o_ret_valid  <= w_ret;
    end
  end

  // targets only load with their strobe
  always_ff @(posedge i_clk) begin
    if (w_call) begin
      o_call_target <= w_call_target;
    end
    if (w_ret) begin
      o_ret_target <= w_pop_addr;
    end
  end

endmodule

`default_nettype wire

/* rtl/ras_stack.sv */
`default_nettype none

`include "ras_predictor_settings.svh"

module ras_stack
  import ras_predictor_pkg::*;
(
  input  wire logic       i_clk,
  input  wire logic       i_reset_n,
  input  wire logic       i_push,
  input  wire hw_addr_t   i_push_addr,
  input  wire logic       i_pop,
  input  wire logic       i_flush_valid,
  input  wire ras_index_t i_flush_index,
  output hw_addr_t        o_pop_addr,
  output ras_index_t      o_index
);

  hw_addr_t   r_entry [`RAS_ENTRIES];
  ras_index_t r_index;

  ras_index_t w_base;
  ras_index_t w_base_m1;
  ras_index_t w_next_index;

  // ----------------------------------------
  // index arithmetic
  // ----------------------------------------

  // flush restores first, fetch then works on top of it
  assign w_base    = i_flush_valid ? i_flush_index : r_index;
  assign w_base_m1 = w_base - ras_index_t'(1);

  always_comb begin
    w_next_index = w_base;
    if (i_push) begin
      w_next_index = w_base + ras_index_t'(1);
    end else if (i_pop) begin
      w_next_index = w_base_m1;
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_index <= '0;
    end else begin
      r_index <= w_next_index;
    end
  end

  // ----------------------------------------
  // entry storage
  // ----------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < `RAS_ENTRIES; i++) begin
        r_entry[i] <= '0;
      end
    end else if (i_push) begin
      r_entry[w_base] <= i_push_addr;
    end
  end

  // top of stack relative to the working base
  assign o_pop_addr = r_entry[w_base_m1];
  assign o_index    = r_index;

endmodule

`default_nettype wire

/* rtl/call_target_calc.sv */
`default_nettype none

module call_target_calc
  import ras_predictor_pkg::*;
(
  input  wire hw_addr_t   i_block_vaddr,
  input  wire hw_pos_t    i_pos,
  input  wire inst_word_t i_inst,
  output hw_addr_t        o_call_target,
  output hw_addr_t        o_return_addr
);

  localparam int ADDR_W = $bits(hw_addr_t);

  logic [19:0] w_imm;
  hw_addr_t    w_offset;
  hw_addr_t    w_pos;
  hw_addr_t    w_inst_base;

  // J-type immediate in halfword units
  assign w_imm = {i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21]};

  assign w_offset = {{(ADDR_W-20){w_imm[19]}}, w_imm};

  assign w_pos = hw_addr_t'(i_pos);

  // slot is the upper half so the call starts one halfword earlier
  assign w_inst_base = i_block_vaddr + w_pos - hw_addr_t'(1);

  assign o_call_target = w_inst_base + w_offset;

  // next halfword after the upper half of the call
  assign o_return_addr = i_block_vaddr + w_pos + hw_addr_t'(1);

endmodule

`default_nettype wire

/* rtl/fetch_branch_decode.sv */
`default_nettype none

`include "ras_predictor_settings.svh"

module fetch_branch_decode
  import ras_predictor_pkg::*;
(
  input  wire logic        i_clk,
  input  wire logic        i_reset_n,
  input  wire logic        i_fetch_valid,
  input  wire hw_addr_t    i_fetch_vaddr,
  input  wire block_data_t i_fetch_data,
  input  wire hw_mask_t    i_fetch_hw_en,
  output logic             o_call,
  output logic             o_ret,
  output hw_pos_t          o_sel_pos,
  output inst_word_t       o_sel_inst
);

  localparam int ADDR_W  = $bits(hw_addr_t);
  localparam int BLK_LSB = $clog2(`RAS_BLOCK_HW);
  localparam int BLK_W   = ADDR_W - BLK_LSB;

  logic [15:0]      w_hw     [`RAS_BLOCK_HW];
  inst_word_t       w_inst32 [`RAS_BLOCK_HW];
  hw_mask_t         w_start;
  hw_mask_t         w_upper;
  hw_mask_t         w_call;
  hw_mask_t         w_ret;
  hw_mask_t         w_other;
  logic [BLK_W-1:0] w_blk;
  logic             w_consec;
  hw_pos_t          w_sel_pos;
  logic             w_found;

  logic [BLK_W-1:0] r_prev_blk_p1;
  logic             r_prev_last_32;
  logic [15:0]      r_prev_last_hw;

  // ----------------------------------------
  // straddle tracking
  // ----------------------------------------
  assign w_blk    = i_fetch_vaddr[ADDR_W-1:BLK_LSB];
  assign w_consec = (w_blk == r_prev_blk_p1);

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_prev_blk_p1  <= '0;
      r_prev_last_32 <= 1'b0;
    end else if (i_fetch_valid) begin
      r_prev_blk_p1  <= w_blk + BLK_W'(1);
      r_prev_last_32 <= w_start[`RAS_BLOCK_HW-1];
    end
  end

  // lower half of a possible straddler
  always_ff @(posedge i_clk) begin
    if (i_fetch_valid) begin
      r_prev_last_hw <= w_hw[`RAS_BLOCK_HW-1];
    end
  end

  // 32-bit start chain seeded at slot 0 from the previous block
  always_comb begin
    w_upper[0] = w_consec & r_prev_last_32;
    w_start[0] = (w_hw[0][1:0] == 2'b11) & ~w_upper[0];
    for (int i = 1; i < `RAS_BLOCK_HW; i++) begin
      w_upper[i] = w_start[i-1];
      w_start[i] = (w_hw[i][1:0] == 2'b11) & ~w_upper[i];
    end
  end

  // ----------------------------------------
  // per-slot classification
  // ----------------------------------------
  for (genvar i = 0; i < `RAS_BLOCK_HW; i++) begin : g_pos
    logic [15:0] c;
    inst_word_t  s;
    logic        c_j;
    logic        c_jr;
    logic        c_jalr;
    logic        s_jal;
    logic        s_jalr;
    logic        s_ret;

    assign w_hw[i] = i_fetch_data[i*16 +: 16];

    if (i == 0) begin : g_first
      assign w_inst32[i] = {w_hw[0], r_prev_last_hw};
    end else begin : g_rest
      assign w_inst32[i] = {w_hw[i], w_hw[i-1]};
    end

    assign c = w_hw[i];
    assign s = w_inst32[i];

    // compressed forms with rs2 zero for jr and jalr
    assign c_j    = (c[1:0] == 2'b01) & (c[15:13] == 3'b101);
    assign c_jr   = (c[1:0] == 2'b10) & (c[15:12] == 4'b1000) &
                    (c[11:7] != 5'd0) & (c[6:2] == 5'd0);
    assign c_jalr = (c[1:0] == 2'b10) & (c[15:12] == 4'b1001) &
                    (c[11:7] != 5'd0) & (c[6:2] == 5'd0);

    assign s_jal  = (s[6:0] == 7'b1101111);
    assign s_jalr = (s[6:0] == 7'b1100111) & (s[14:12] == 3'b000);
    // jalr x0, 0(x1)
    assign s_ret  = s_jalr & (s[11:7] == 5'd0) & (s[19:15] == 5'd1) &
                    (s[31:20] == 12'd0);

    assign w_call[i]  = i_fetch_hw_en[i] & w_upper[i] & s_jal & (s[11:7] == 5'd1);
    assign w_ret[i]   = i_fetch_hw_en[i] &
                        ((~w_upper[i] & c_jr & (c[11:7] == 5'd1)) |
                         (w_upper[i] & s_ret));
    assign w_other[i] = i_fetch_hw_en[i] &
                        ((~w_upper[i] & (c_j | c_jalr | (c_jr & (c[11:7] != 5'd1)))) |
                         (w_upper[i] & ((s_jal & (s[11:7] != 5'd1)) |
                                        (s_jalr & ~s_ret))));
  end

  // ----------------------------------------
  // first transfer wins
  // ----------------------------------------
  always_comb begin
    w_sel_pos = '0;
    w_found   = 1'b0;
    for (int i = `RAS_BLOCK_HW-1; i >= 0; i--) begin
      if (w_call[i] | w_ret[i] | w_other[i]) begin
        w_sel_pos = hw_pos_t'(i);
        w_found   = 1'b1;
      end
    end
  end

  assign o_call     = i_fetch_valid & w_found & w_call[w_sel_pos];
  assign o_ret      = i_fetch_valid & w_found & w_ret[w_sel_pos];
  assign o_sel_pos  = w_sel_pos;
  assign o_sel_inst = w_inst32[w_sel_pos];

endmodule

`default_nettype wire

/* rtl/ras_predictor_pkg.sv */
`default_nettype none

`include "ras_predictor_settings.svh"

package ras_predictor_pkg;

  // one bit per halfword slot in a block
  typedef logic [`RAS_BLOCK_HW-1:0] hw_mask_t;
  typedef logic [$clog2(`RAS_BLOCK_HW)-1:0] hw_pos_t;

  // virtual address without bit 0
  typedef logic [`RAS_VADDR_W-2:0] hw_addr_t;

  typedef logic [$clog2(`RAS_ENTRIES)-1:0] ras_index_t;

  typedef logic [31:0] inst_word_t;
  typedef logic [16*`RAS_BLOCK_HW-1:0] block_data_t;

endpackage

`default_nettype wire

/* rtl/ras_predictor_settings.svh */
`ifndef RAS_PREDICTOR_SETTINGS_SVH
`define RAS_PREDICTOR_SETTINGS_SVH

// halfwords per fetch block
`define RAS_BLOCK_HW 4

// virtual address width in bits
`define RAS_VADDR_W 39

// return address stack depth
// power of two so the index wraps by itself
`define RAS_ENTRIES 8

`endif
